/* build.f */
source/cache_ri_pkg.sv
source/victim_select.sv
source/line_sequencer.sv
source/bus_cmd_queue.sv
source/cache_ri_top.sv
dv/cache_ri_tb.sv

/* run.sh */
#!/bin/sh
# builds the cache_ri testbench with verilator and runs it from the project root.
cd "$(dirname "$0")" || exit 1

rm -rf obj_dir
verilator --binary --timing --timescale 1ns/1ps -f build.f \
  --top-module cache_ri_tb -o cache_ri_sim > build.log 2>&1
if [ $? -ne 0 ]; then
  echo "verilator build failed, see build.log"
  exit 1
fi

./obj_dir/cache_ri_sim > sim.log 2>&1
sim_status=$?
cat sim.log
if [ $sim_status -ne 0 ]; then
  echo "simulation exited with status $sim_status"
  exit 1
fi

if grep -qx "Test passed" sim.log; then
  exit 0
fi
exit 1

/* dv/cache_ri_testdata.txt */
// cmd addr wr_be wdata hit hit_way free free_way dirty victim_tag exp_way
// cmd 1 is uncached, 2 is refill; wr_be 0 means a read, else a write with it
1 00001230 0 00000000 0 0 0 0 0 0  0
1 00002008 3 deadbeef 0 0 0 0 0 0  0
2 000090c0 0 00000000 0 0 1 2 0 0  2
2 00010140 0 00000000 0 0 1 1 1 7  1
2 00018180 0 00000000 1 3 0 0 1 30 3
2 00080240 0 00000000 0 0 0 0 0 0  0
2 00080a40 0 00000000 0 0 0 0 0 0  1
2 00081240 0 00000000 0 0 0 0 0 0  2
2 00081a40 0 00000000 0 0 0 0 0 0  3
2 00082240 0 00000000 0 0 0 0 0 0  0
2 00082a40 0 00000000 0 0 0 0 1 55 1
2 00083240 0 00000000 0 0 1 3 0 0  3
2 00083a40 0 00000000 0 0 0 0 0 0  2
1 0000fffc 0 00000000 0 0 0 0 0 0  0
1 00003000 f 12345678 0 0 0 0 0 0  0

/* dv/cache_ri_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module cache_ri_tb;
  import cache_ri_pkg::*;

  localparam int FIELDS         = 11;
  localparam int MAX_TESTS      = 32;
  localparam int TIMEOUT_CYCLES = 2000;

  logic       clk;
  logic       rest;
  rw_cmd_e    rw_cmd;
  logic       rw_cmd_ready;
  word_t      rw_rsp_data;
  word_t      rw_last_av_s0_address;
  word_t      rw_last_av_s0_writeData;
  byte_en_t   rw_last_av_s0_byteEnable;
  logic       rw_last_av_s0_read;
  logic       rw_last_av_s0_write;
  logic       rw_isHit;
  way_t       rw_hitBlockNum;
  logic       rw_isHaveFreeBlock;
  way_t       rw_freeBlockNum;
  word_t      av_s0_address;
  byte_en_t   av_s0_byteEnable;
  logic       av_s0_read;
  logic       av_s0_write;
  word_t      av_s0_writeData;
  logic       av_s0_waitRequest = 1'b0;
  logic       av_s0_beginBurstTransfer;
  burst_cnt_t av_s0_burstCount;
  word_t      av_s0_readData = '0;
  logic       av_s0_readDataValid = 1'b0;
  data_addr_t data_ri_readAddress;
  way_t       data_ri_rwChannel;
  word_t      data_ri_readData = '0;
  data_addr_t data_ri_writeAddress;
  byte_en_t   data_ri_writeByteEnable;
  logic       data_ri_writeEnable;
  word_t      data_ri_writeData;
  set_t       tag_ri_readAddress;
  way_t       tag_ri_channel;
  word_t      tag_ri_readData = '0;
  set_t       tag_ri_writeAddress;
  logic       tag_ri_writeEnable;
  word_t      tag_ri_writeData;

  // ram contents and line preset requests.
  word_t      data_mem [4][512];
  word_t      tag_mem [4][32];
  logic       preset_req;
  way_t       preset_way;
  set_t       preset_set;
  logic       preset_dirty;
  tag_t       preset_vtag;

  // bus and ram activity, appended as it happens.
  word_t      wr_addr_q [$];
  word_t      wr_data_q [$];
  byte_en_t   wr_be_q [$];
  logic       wr_begin_q [$];
  burst_cnt_t wr_burst_q [$];
  word_t      rd_addr_q [$];
  logic       rd_begin_q [$];
  burst_cnt_t rd_burst_q [$];
  word_t      rsp_q [$];
  way_t       dw_chan_q [$];
  data_addr_t dw_addr_q [$];
  word_t      dw_data_q [$];
  byte_en_t   dw_be_q [$];
  way_t       tw_chan_q [$];
  set_t       tw_addr_q [$];
  word_t      tw_data_q [$];

  word_t       tdata [MAX_TESTS*FIELDS];
  int          err_cnt;
  int          bad_tests;
  logic        timed_out;
  int unsigned seed_val;

  cache_ri_top u_dut (.*);

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  function automatic word_t mem_word(input word_t addr);
    return addr ^ 32'h5a5a_0000;
  endfunction

  function automatic word_t fill_word(input way_t way, input data_addr_t addr);
    return {16'hc0de, 5'd0, way, addr};
  endfunction

  // **************************************************************************
  // avalon slave, one read beat per accepted read command
  // **************************************************************************

  // random wait states from a fixed seed.
  initial begin
    seed_val = $urandom(44);
    forever begin
      @(posedge clk);
      av_s0_waitRequest <= (($urandom % 32'd3) == 32'd0);
    end
  end

  always @(posedge clk) begin
    if (rsp_q.size() > 0) begin
      av_s0_readDataValid <= 1'b1;
      av_s0_readData      <= mem_word(rsp_q.pop_front());
    end else begin
      av_s0_readDataValid <= 1'b0;
    end
    if (rest && av_s0_write && !av_s0_waitRequest) begin
      wr_addr_q.push_back(av_s0_address);
      wr_data_q.push_back(av_s0_writeData);
      wr_be_q.push_back(av_s0_byteEnable);
      wr_begin_q.push_back(av_s0_beginBurstTransfer);
      wr_burst_q.push_back(av_s0_burstCount);
    end
    if (rest && av_s0_read && !av_s0_waitRequest) begin
      rd_addr_q.push_back(av_s0_address);
      rd_begin_q.push_back(av_s0_beginBurstTransfer);
      rd_burst_q.push_back(av_s0_burstCount);
      rsp_q.push_back(av_s0_address);
    end
  end

  // **************************************************************************
  // data and tag rams, one cycle read
  // **************************************************************************
  always @(posedge clk) begin
    data_ri_readData <= data_mem[data_ri_rwChannel][data_ri_readAddress];
    tag_ri_readData  <= tag_mem[tag_ri_channel][tag_ri_readAddress];
    if (data_ri_writeEnable) begin
      data_mem[data_ri_rwChannel][data_ri_writeAddress] <= data_ri_writeData;
      dw_chan_q.push_back(data_ri_rwChannel);
      dw_addr_q.push_back(data_ri_writeAddress);
      dw_data_q.push_back(data_ri_writeData);
      dw_be_q.push_back(data_ri_writeByteEnable);
    end
    if (tag_ri_writeEnable) begin
      tag_mem[tag_ri_channel][tag_ri_writeAddress] <= tag_ri_writeData;
      tw_chan_q.push_back(tag_ri_channel);
      tw_addr_q.push_back(tag_ri_writeAddress);
      tw_data_q.push_back(tag_ri_writeData);
    end
    // victim line, valid, dirty as asked.
    if (preset_req) begin
      tag_mem[preset_way][preset_set] <= {9'd0, preset_dirty, 1'b1, preset_vtag};
      for (int i = 0; i < LINE_WORDS; i++) begin
        data_mem[preset_way][{preset_set, i[3:0]}] <= fill_word(preset_way, {preset_set, i[3:0]});
      end
    end
  end

  task automatic check_value(input string what, input word_t got, input word_t exp);
    if (got !== exp) begin
      $display("Error at %0t ns: %s, got %h, expected %h", $time, what, got, exp);
      err_cnt++;
    end
  endtask

  task automatic run_test(input int t);
    word_t cmd;
    word_t addr;
    word_t be_w;
    word_t wdata;
    word_t hit;
    word_t hit_way;
    word_t free;
    word_t free_way;
    word_t dirty;
    word_t vtag;
    word_t exp_way;
    word_t line_base;
    word_t victim_base;
    word_t rsp;
    set_t  set;
    logic  got_ready;
    int    cycles;
    int    errs_before;
    int    exp_wb;
    int    n;
    int    i;
    int    wr_base;
    int    rd_base;
    int    dw_base;
    int    tw_base;
    cmd         = tdata[t*FIELDS+0];
    addr        = tdata[t*FIELDS+1];
    be_w        = tdata[t*FIELDS+2];
    wdata       = tdata[t*FIELDS+3];
    hit         = tdata[t*FIELDS+4];
    hit_way     = tdata[t*FIELDS+5];
    free        = tdata[t*FIELDS+6];
    free_way    = tdata[t*FIELDS+7];
    dirty       = tdata[t*FIELDS+8];
    vtag        = tdata[t*FIELDS+9];
    exp_way     = tdata[t*FIELDS+10];
    set         = addr[10:6];
    line_base   = {addr[31:6], 6'd0};
    victim_base = {vtag[20:0], set, 6'd0};
    errs_before = err_cnt;
    wr_base     = wr_addr_q.size();
    rd_base     = rd_addr_q.size();
    dw_base     = dw_addr_q.size();
    tw_base     = tw_addr_q.size();
    if (cmd == 32'd2) begin
      @(posedge clk);
      preset_req   <= 1'b1;
      preset_way   <= exp_way[1:0];
      preset_set   <= set;
      preset_dirty <= dirty[0];
      preset_vtag  <= vtag[20:0];
    end
    @(posedge clk);
    preset_req               <= 1'b0;
    rw_cmd                   <= rw_cmd_e'(cmd[3:0]);
    rw_last_av_s0_address    <= addr;
    rw_last_av_s0_read       <= (be_w == 32'd0);
    rw_last_av_s0_write      <= (be_w != 32'd0);
    rw_last_av_s0_byteEnable <= (be_w == 32'd0) ? 4'hf : be_w[3:0];
    rw_last_av_s0_writeData  <= wdata;
    rw_isHit                 <= hit[0];
    rw_hitBlockNum           <= hit_way[1:0];
    rw_isHaveFreeBlock       <= free[0];
    rw_freeBlockNum          <= free_way[1:0];
    @(posedge clk);
    rw_cmd <= rw_nop;
    got_ready = 1'b0;
    cycles    = 0;
    rsp       = '0;
    while (!got_ready && cycles < TIMEOUT_CYCLES) begin
      @(negedge clk);
      if (rw_cmd_ready) begin
        got_ready = 1'b1;
        rsp       = rw_rsp_data;
      end
      cycles++;
    end
    if (!got_ready) begin
      $display("test %0d timed out, no rw_cmd_ready after %0d cycles", t, cycles);
      timed_out = 1'b1;
      return;
    end
    repeat (3) @(posedge clk);

    if (cmd == 32'd1 && be_w == 32'd0) begin
      check_value("uncached read count", rd_addr_q.size() - rd_base, 1);
      check_value("uncached write count", wr_addr_q.size() - wr_base, 0);
      if (rd_addr_q.size() > rd_base) begin
        check_value("read address", rd_addr_q[rd_base], addr);
        check_value("read burst count", {27'd0, rd_burst_q[rd_base]}, 32'd1);
      end
      check_value("read response", rsp, mem_word(addr));
    end else if (cmd == 32'd1) begin
      check_value("uncached write count", wr_addr_q.size() - wr_base, 1);
      check_value("uncached read count", rd_addr_q.size() - rd_base, 0);
      if (wr_addr_q.size() > wr_base) begin
        check_value("write address", wr_addr_q[wr_base], addr);
        check_value("write data", wr_data_q[wr_base], wdata);
        check_value("write byte enable", {28'd0, wr_be_q[wr_base]}, {28'd0, be_w[3:0]});
        check_value("write burst count", {27'd0, wr_burst_q[wr_base]}, 32'd1);
      end
    end else begin
      // write-back only for a dirty victim that missed.
      exp_wb = (dirty[0] && !hit[0]) ? LINE_WORDS : 0;
      n = wr_addr_q.size() - wr_base;
      check_value("write-back beats", n, exp_wb);
      for (i = 0; i < n && i < exp_wb; i++) begin
        check_value($sformatf("write-back %0d address", i), wr_addr_q[wr_base+i],
                    victim_base + 32'(i) * 32'(WORD_BYTES));
        check_value($sformatf("write-back %0d data", i), wr_data_q[wr_base+i],
                    fill_word(exp_way[1:0], {set, i[3:0]}));
        check_value($sformatf("write-back %0d byte enable", i), {28'd0, wr_be_q[wr_base+i]},
                    32'hf);
        check_value($sformatf("write-back %0d begin burst", i), {31'd0, wr_begin_q[wr_base+i]},
                    (i == 0) ? 32'd1 : 32'd0);
        check_value($sformatf("write-back %0d burst count", i),
                    {27'd0, wr_burst_q[wr_base+i]}, 32'(LINE_WORDS));
      end
      n = rd_addr_q.size() - rd_base;
      check_value("refill reads", n, LINE_WORDS);
      for (i = 0; i < n && i < LINE_WORDS; i++) begin
        check_value($sformatf("refill %0d address", i), rd_addr_q[rd_base+i],
                    line_base + 32'(i) * 32'(WORD_BYTES));
        check_value($sformatf("refill %0d begin burst", i), {31'd0, rd_begin_q[rd_base+i]},
                    (i == 0) ? 32'd1 : 32'd0);
        check_value($sformatf("refill %0d burst count", i), {27'd0, rd_burst_q[rd_base+i]},
                    32'(LINE_WORDS));
      end
      n = dw_addr_q.size() - dw_base;
      check_value("data ram writes", n, LINE_WORDS);
      for (i = 0; i < n && i < LINE_WORDS; i++) begin
        check_value($sformatf("data write %0d way", i), {30'd0, dw_chan_q[dw_base+i]}, exp_way);
        check_value($sformatf("data write %0d address", i), {23'd0, dw_addr_q[dw_base+i]},
                    {23'd0, set, i[3:0]});
        check_value($sformatf("data write %0d word", i), dw_data_q[dw_base+i],
                    mem_word(line_base + 32'(i) * 32'(WORD_BYTES)));
        check_value($sformatf("data write %0d byte enable", i), {28'd0, dw_be_q[dw_base+i]},
                    32'hf);
      end
      check_value("tag ram writes", tw_addr_q.size() - tw_base, 1);
      if (tw_addr_q.size() > tw_base) begin
        check_value("tag write way", {30'd0, tw_chan_q[tw_base]}, exp_way);
        check_value("tag write set", {27'd0, tw_addr_q[tw_base]}, {27'd0, set});
        check_value("tag write word", tw_data_q[tw_base], {9'd0, 1'b0, 1'b1, addr[31:11]});
      end
    end
    if (err_cnt != errs_before) begin
      bad_tests++;
      $display("test %0d cmd %0d addr %h: mismatch", t, cmd, addr);
    end else begin
      $display("test %0d cmd %0d addr %h: ok", t, cmd, addr);
    end
  endtask

  // **************************************************************************
  // main sequence
  // **************************************************************************
  initial begin
    int n_tests;
    int t;
    err_cnt                  = 0;
    bad_tests                = 0;
    timed_out                = 1'b0;
    rest                     <= 1'b0;
    rw_cmd                   <= rw_nop;
    rw_last_av_s0_address    <= '0;
    rw_last_av_s0_writeData  <= '0;
    rw_last_av_s0_byteEnable <= '0;
    rw_last_av_s0_read       <= 1'b0;
    rw_last_av_s0_write      <= 1'b0;
    rw_isHit                 <= 1'b0;
    rw_hitBlockNum           <= '0;
    rw_isHaveFreeBlock       <= 1'b0;
    rw_freeBlockNum          <= '0;
    preset_req               <= 1'b0;
    preset_way               <= '0;
    preset_set               <= '0;
    preset_dirty             <= 1'b0;
    preset_vtag              <= '0;
    for (int k = 0; k < MAX_TESTS*FIELDS; k++) begin
      tdata[k] = '1;
    end
    $readmemh("dv/cache_ri_testdata.txt", tdata);
    n_tests = 0;
    while (n_tests < MAX_TESTS && tdata[n_tests*FIELDS] != 32'hffff_ffff) begin
      n_tests++;
    end
    repeat (8) @(posedge clk);
    rest <= 1'b1;
    repeat (2) @(posedge clk);
    for (t = 0; t < n_tests && !timed_out; t++) begin
      run_test(t);
    end
    if (n_tests == 0) begin
      $display("no test vectors found in dv/cache_ri_testdata.txt");
    end
    $display("%0d tests run, %0d with mismatches, %0d check errors", t, bad_tests, err_cnt);
    if (err_cnt == 0 && !timed_out && n_tests > 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* source/cache_ri_top.sv */
`timescale 1ns/1ps
`default_nettype none

module cache_ri_top (
  input  logic                     clk,
  input  logic                     rest,
  // request side.
  input  cache_ri_pkg::rw_cmd_e    rw_cmd,
  output logic                     rw_cmd_ready,
  output cache_ri_pkg::word_t      rw_rsp_data,
  input  cache_ri_pkg::word_t      rw_last_av_s0_address,
  input  cache_ri_pkg::word_t      rw_last_av_s0_writeData,
  input  cache_ri_pkg::byte_en_t   rw_last_av_s0_byteEnable,
  input  logic                     rw_last_av_s0_read,
  input  logic                     rw_last_av_s0_write,
  input  logic                     rw_isHit,
  input  cache_ri_pkg::way_t       rw_hitBlockNum,
  input  logic                     rw_isHaveFreeBlock,
  input  cache_ri_pkg::way_t       rw_freeBlockNum,
  // avalon master.
  output cache_ri_pkg::word_t      av_s0_address,
  output cache_ri_pkg::byte_en_t   av_s0_byteEnable,
  output logic                     av_s0_read,
  output logic                     av_s0_write,
  output cache_ri_pkg::word_t      av_s0_writeData,
  input  logic                     av_s0_waitRequest,
  output logic                     av_s0_beginBurstTransfer,
  output cache_ri_pkg::burst_cnt_t av_s0_burstCount,
  input  cache_ri_pkg::word_t      av_s0_readData,
  input  logic                     av_s0_readDataValid,
  // data ram.
  output cache_ri_pkg::data_addr_t data_ri_readAddress,
  output cache_ri_pkg::way_t       data_ri_rwChannel,
  input  cache_ri_pkg::word_t      data_ri_readData,
  output cache_ri_pkg::data_addr_t data_ri_writeAddress,
  output cache_ri_pkg::byte_en_t   data_ri_writeByteEnable,
  output logic                     data_ri_writeEnable,
  output cache_ri_pkg::word_t      data_ri_writeData,
  // tag ram.
  output cache_ri_pkg::set_t       tag_ri_readAddress,
  output cache_ri_pkg::way_t       tag_ri_channel,
  input  cache_ri_pkg::word_t      tag_ri_readData,
  output cache_ri_pkg::set_t       tag_ri_writeAddress,
  output logic                     tag_ri_writeEnable,
  output cache_ri_pkg::word_t      tag_ri_writeData
);
  import cache_ri_pkg::*;

  // **************************************************************************
  // stage 1 to stage 2
  // **************************************************************************
  logic     job_start;
  word_t    job_addr;
  logic     job_read;
  logic     job_write;
  byte_en_t job_byte_en;
  word_t    job_wdata;
  logic     job_refill;
  way_t     job_way;
  logic     job_hit;
  logic     busy;

  // **************************************************************************
  // stage 2 to stage 3
  // **************************************************************************
  logic       push;
  word_t      cmd_addr;
  byte_en_t   cmd_byte_en;
  logic       cmd_read;
  logic       cmd_write;
  word_t      cmd_wdata;
  logic       cmd_begin_burst;
  burst_cnt_t cmd_burst_count;
  logic       queue_full;
  logic       queue_empty;

  // uncached read data straight off the bus.
  assign rw_rsp_data = av_s0_readData;

  victim_select u_victim_select (.*);

  line_sequencer u_line_sequencer (.*);

  bus_cmd_queue u_bus_cmd_queue (.*);

endmodule

`default_nettype wire

/* source/bus_cmd_queue.sv */
`timescale 1ns/1ps
`default_nettype none

module bus_cmd_queue (
  input  logic                     clk,
  input  logic                     rest,
  input  logic                     push,
  input  cache_ri_pkg::word_t      cmd_addr,
  input  cache_ri_pkg::byte_en_t   cmd_byte_en,
  input  logic                     cmd_read,
  input  logic                     cmd_write,
  input  cache_ri_pkg::word_t      cmd_wdata,
  input  logic                     cmd_begin_burst,
  input  cache_ri_pkg::burst_cnt_t cmd_burst_count,
  input  logic                     av_s0_waitRequest,
  output logic                     queue_full,
  output logic                     queue_empty,
  output cache_ri_pkg::word_t      av_s0_address,
  output cache_ri_pkg::byte_en_t   av_s0_byteEnable,
  output logic                     av_s0_read,
  output logic                     av_s0_write,
  output cache_ri_pkg::word_t      av_s0_writeData,
  output logic                     av_s0_beginBurstTransfer,
  output cache_ri_pkg::burst_cnt_t av_s0_burstCount
);
  import cache_ri_pkg::*;

  typedef logic [$clog2(BUS_QUEUE_DEPTH)-1:0]   ptr_t;
  typedef logic [$clog2(BUS_QUEUE_DEPTH+1)-1:0] count_t;

  word_t      q_addr  [BUS_QUEUE_DEPTH];
  byte_en_t   q_be    [BUS_QUEUE_DEPTH];
  logic       q_read  [BUS_QUEUE_DEPTH];
  logic       q_write [BUS_QUEUE_DEPTH];
  word_t      q_wdata [BUS_QUEUE_DEPTH];
  logic       q_begin [BUS_QUEUE_DEPTH];
  burst_cnt_t q_burst [BUS_QUEUE_DEPTH];
  ptr_t       wr_ptr;
  ptr_t       rd_ptr;
  count_t     count;
  logic       wr_en;
  logic       rd_en;

  assign queue_empty = (count == '0);
  assign queue_full  = (count == count_t'(BUS_QUEUE_DEPTH));
  assign rd_en       = !queue_empty && !av_s0_waitRequest;
  // bypassed command taken by the bus at once is never stored.
  assign wr_en       = push && !(queue_empty && !av_s0_waitRequest);

  always_ff @(posedge clk or negedge rest) begin
    if (!rest) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (wr_en) wr_ptr <= wr_ptr + ptr_t'(1);
      if (rd_en) rd_ptr <= rd_ptr + ptr_t'(1);
      case ({wr_en, rd_en})
        2'b10:   count <= count + count_t'(1);
        2'b01:   count <= count - count_t'(1);
        default: count <= count;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (wr_en) begin
      q_addr[wr_ptr]  <= cmd_addr;
      q_be[wr_ptr]    <= cmd_byte_en;
      q_read[wr_ptr]  <= cmd_read;
      q_write[wr_ptr] <= cmd_write;
      q_wdata[wr_ptr] <= cmd_wdata;
      q_begin[wr_ptr] <= cmd_begin_burst;
      q_burst[wr_ptr] <= cmd_burst_count;
    end
  end

  // head of queue, or the incoming command when empty.
  assign av_s0_address            = queue_empty ? cmd_addr : q_addr[rd_ptr];
  assign av_s0_byteEnable         = queue_empty ? cmd_byte_en : q_be[rd_ptr];
  assign av_s0_read               = queue_empty ? (push && cmd_read) : q_read[rd_ptr];
  assign av_s0_write              = queue_empty ? (push && cmd_write) : q_write[rd_ptr];
  assign av_s0_writeData          = queue_empty ? cmd_wdata : q_wdata[rd_ptr];
  assign av_s0_beginBurstTransfer = queue_empty ? (push && cmd_begin_burst) : q_begin[rd_ptr];
  assign av_s0_burstCount         = queue_empty ? cmd_burst_count : q_burst[rd_ptr];

endmodule

`default_nettype wire

/* source/line_sequencer.sv */
`timescale 1ns/1ps
`default_nettype none

module line_sequencer (
  input  logic                     clk,
  input  logic                     rest,
  input  logic                     job_start,
  input  cache_ri_pkg::word_t      job_addr,
  input  logic                     job_read,
  input  logic                     job_write,
  input  cache_ri_pkg::byte_en_t   job_byte_en,
  input  cache_ri_pkg::word_t      job_wdata,
  input  logic                     job_refill,
  input  cache_ri_pkg::way_t       job_way,
  input  logic                     job_hit,
  input  logic                     queue_full,
  input  logic                     queue_empty,
  input  logic                     av_s0_waitRequest,
  input  logic                     av_s0_readDataValid,
  input  cache_ri_pkg::word_t      av_s0_readData,
  input  cache_ri_pkg::word_t      data_ri_readData,
  input  cache_ri_pkg::word_t      tag_ri_readData,
  output logic                     busy,
  output logic                     rw_cmd_ready,
  output logic                     push,
  output cache_ri_pkg::word_t      cmd_addr,
  output cache_ri_pkg::byte_en_t   cmd_byte_en,
  output logic                     cmd_read,
  output logic                     cmd_write,
  output cache_ri_pkg::word_t      cmd_wdata,
  output logic                     cmd_begin_burst,
  output cache_ri_pkg::burst_cnt_t cmd_burst_count,
  output cache_ri_pkg::data_addr_t data_ri_readAddress,
  output cache_ri_pkg::data_addr_t data_ri_writeAddress,
  output cache_ri_pkg::way_t       data_ri_rwChannel,
  output cache_ri_pkg::byte_en_t   data_ri_writeByteEnable,
  output logic                     data_ri_writeEnable,
  output cache_ri_pkg::word_t      data_ri_writeData,
  output cache_ri_pkg::set_t       tag_ri_readAddress,
  output cache_ri_pkg::set_t       tag_ri_writeAddress,
  output cache_ri_pkg::way_t       tag_ri_channel,
  output logic                     tag_ri_writeEnable,
  output cache_ri_pkg::word_t      tag_ri_writeData
);
  import cache_ri_pkg::*;

  typedef enum logic [2:0] {
    idle, io_wait, tag_check, write_back, refill, done
  } seq_state_e;

  seq_state_e state;
  set_t       job_set;
  tag_t       job_tag;
  tag_t       victim_tag;
  word_t      line_base;
  word_t      victim_base;
  // ram reads, queue pushes, bus beats.
  beat_t      rd_cnt;
  beat_t      push_cnt;
  beat_t      acc_cnt;
  logic       rd_pending;
  logic       hold_valid;
  word_t      hold_data;
  logic       word_avail;
  word_t      word_data;
  logic       rd_issue;
  logic       wr_accept;
  logic       rf_beat;
  logic       io_end;
  logic       line_end;
  logic       push_left;

  assign job_set     = job_addr[TAG_RAM_ADDR_WIDTH+5:6];
  assign job_tag     = job_addr[31 -: TAG_ADDR_WIDTH];
  assign line_base   = {job_tag, job_set, {(32 - TAG_ADDR_WIDTH - TAG_RAM_ADDR_WIDTH){1'b0}}};
  assign victim_base = {victim_tag, job_set, {(32 - TAG_ADDR_WIDTH - TAG_RAM_ADDR_WIDTH){1'b0}}};

  assign busy       = job_start || (state != idle);
  assign push_left  = (push_cnt < beat_t'(LINE_WORDS));
  assign line_end   = (acc_cnt == beat_t'(LINE_WORDS)) && queue_empty;
  assign io_end     = (state == io_wait) && queue_empty &&
                      (job_read ? av_s0_readDataValid : !av_s0_waitRequest);
  assign rw_cmd_ready = io_end || (state == done);

  // write-back word path, one ram read in flight or one word held.
  assign word_avail = rd_pending || hold_valid;
  assign word_data  = hold_valid ? hold_data : data_ri_readData;
  assign rd_issue   = (state == write_back) && (rd_cnt < beat_t'(LINE_WORDS)) &&
                      (!word_avail || push);
  assign wr_accept  = (state == write_back) && (push || !queue_empty) && !av_s0_waitRequest;
  assign rf_beat    = (state == refill) && av_s0_readDataValid;

  assign data_ri_readAddress     = {job_set, rd_cnt[3:0]};
  assign data_ri_rwChannel       = job_way;
  assign data_ri_writeByteEnable = '1;
  assign tag_ri_readAddress      = job_set;
  assign tag_ri_writeAddress     = job_set;
  assign tag_ri_channel          = job_way;
  // valid, clean, new tag.
  assign tag_ri_writeData        = {{(31 - TAG_VALID_BIT){1'b0}}, 1'b1, job_tag};

  always_comb begin
    push            = 1'b0;
    cmd_addr        = job_addr;
    cmd_byte_en     = job_byte_en;
    cmd_read        = job_read;
    cmd_write       = job_write;
    cmd_wdata       = job_wdata;
    cmd_begin_burst = 1'b0;
    cmd_burst_count = burst_cnt_t'(1);
    case (state)
      idle: push = job_start && !job_refill;
      write_back, refill: begin
        cmd_byte_en     = '1;
        cmd_read        = (state == refill);
        cmd_write       = (state == write_back);
        cmd_wdata       = word_data;
        cmd_begin_burst = (push_cnt == '0);
        cmd_burst_count = burst_cnt_t'(LINE_WORDS);
        if (state == write_back) begin
          push     = word_avail && !queue_full && push_left;
          cmd_addr = victim_base + word_t'(push_cnt) * word_t'(WORD_BYTES);
        end else begin
          push     = !queue_full && push_left;
          cmd_addr = line_base + word_t'(push_cnt) * word_t'(WORD_BYTES);
        end
      end
      default: push = 1'b0;
    endcase
  end

  always_ff @(posedge clk or negedge rest) begin
    if (!rest) begin
      state               <= idle;
      rd_cnt              <= '0;
      push_cnt            <= '0;
      acc_cnt             <= '0;
      rd_pending          <= 1'b0;
      hold_valid          <= 1'b0;
      data_ri_writeEnable <= 1'b0;
      tag_ri_writeEnable  <= 1'b0;
    end else begin
      rd_pending          <= rd_issue;
      data_ri_writeEnable <= rf_beat;
      // tag goes in with the first refill beat.
      tag_ri_writeEnable  <= rf_beat && (acc_cnt == '0);
      case (state)
        idle: if (job_start) state <= job_refill ? tag_check : io_wait;
        io_wait: if (io_end) state <= idle;
        tag_check: begin
          rd_cnt   <= '0;
          push_cnt <= '0;
          acc_cnt  <= '0;
          state    <= (tag_ri_readData[TAG_DIRTY_BIT] && !job_hit) ? write_back : refill;
        end
        write_back: begin
          if (rd_issue) rd_cnt <= rd_cnt + beat_t'(1);
          if (push) push_cnt <= push_cnt + beat_t'(1);
          if (wr_accept) acc_cnt <= acc_cnt + beat_t'(1);
          if (rd_pending && !push) begin
            hold_valid <= 1'b1;
          end else if (push) begin
            hold_valid <= 1'b0;
          end
          if (line_end) begin
            state    <= refill;
            rd_cnt   <= '0;
            push_cnt <= '0;
            acc_cnt  <= '0;
          end
        end
        refill: begin
          if (push) push_cnt <= push_cnt + beat_t'(1);
          if (av_s0_readDataValid) acc_cnt <= acc_cnt + beat_t'(1);
          if (line_end) state <= done;
        end
        done: state <= idle;
        default: state <= idle;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == tag_check) victim_tag <= tag_ri_readData[TAG_ADDR_WIDTH-1:0];
    if (rd_pending && !push) hold_data <= data_ri_readData;
    if (rf_beat) begin
      data_ri_writeAddress <= {job_set, acc_cnt[3:0]};
      data_ri_writeData    <= av_s0_readData;
    end
  end

endmodule

`default_nettype wire

/* source/victim_select.sv */
`timescale 1ns/1ps
`default_nettype none

module victim_select (
  input  logic                   clk,
  input  logic                   rest,
  input  cache_ri_pkg::rw_cmd_e  rw_cmd,
  input  cache_ri_pkg::word_t    rw_last_av_s0_address,
  input  logic                   rw_last_av_s0_read,
  input  logic                   rw_last_av_s0_write,
  input  cache_ri_pkg::byte_en_t rw_last_av_s0_byteEnable,
  input  cache_ri_pkg::word_t    rw_last_av_s0_writeData,
  input  logic                   rw_isHit,
  input  cache_ri_pkg::way_t     rw_hitBlockNum,
  input  logic                   rw_isHaveFreeBlock,
  input  cache_ri_pkg::way_t     rw_freeBlockNum,
  input  logic                   busy,
  output logic                   job_start,
  output cache_ri_pkg::word_t    job_addr,
  output logic                   job_read,
  output logic                   job_write,
  output cache_ri_pkg::byte_en_t job_byte_en,
  output cache_ri_pkg::word_t    job_wdata,
  output logic                   job_refill,
  output cache_ri_pkg::way_t     job_way,
  output logic                   job_hit
);
  import cache_ri_pkg::*;

  // round-robin replacement counter per set.
  way_t rr_cnt [2**TAG_RAM_ADDR_WIDTH];
  set_t req_set;
  logic accept;
  logic evict;

  assign req_set = rw_last_av_s0_address[TAG_RAM_ADDR_WIDTH+5:6];
  assign accept  = (rw_cmd != rw_nop) && !busy;
  // miss with every way taken.
  assign evict   = (rw_cmd == rw_refill) && !rw_isHit && !rw_isHaveFreeBlock;

  always_ff @(posedge clk or negedge rest) begin
    if (!rest) begin
      job_start <= 1'b0;
      for (int i = 0; i < 2**TAG_RAM_ADDR_WIDTH; i++) begin
        rr_cnt[i] <= '0;
      end
    end else begin
      job_start <= accept;
      if (accept && evict) begin
        rr_cnt[req_set] <= rr_cnt[req_set] + way_t'(1);
      end
    end
  end

  // job payload, read by the sequencer only after job_start.
  always_ff @(posedge clk) begin
    if (accept) begin
      job_addr    <= rw_last_av_s0_address;
      job_read    <= rw_last_av_s0_read;
      job_write   <= rw_last_av_s0_write;
      job_byte_en <= rw_last_av_s0_byteEnable;
      job_wdata   <= rw_last_av_s0_writeData;
      job_refill  <= (rw_cmd == rw_refill);
      job_hit     <= rw_isHit;
      if (rw_isHit) begin
        job_way <= rw_hitBlockNum;
      end else if (rw_isHaveFreeBlock) begin
        job_way <= rw_freeBlockNum;
      end else begin
        job_way <= rr_cnt[req_set];
      end
    end
  end

endmodule

`default_nettype wire

/* source/cache_ri_pkg.sv */
`default_nettype none

package cache_ri_pkg;

  // **************************************************************************
  // widths
  // **************************************************************************

  // data ram word address, set index, tag and avalon burst count.
  localparam int unsigned DATA_RAM_ADDR_WIDTH = 9;
  localparam int unsigned TAG_RAM_ADDR_WIDTH  = 5;
  localparam int unsigned TAG_ADDR_WIDTH      = 21;
  localparam int unsigned BURST_COUNT_WIDTH   = 5;

  // one line is one full burst.
  localparam int unsigned LINE_WORDS = 16;
  localparam int unsigned WORD_BYTES = 4;

  // tag ram word layout, tag in the low bits.
  localparam int unsigned TAG_VALID_BIT = 21;
  localparam int unsigned TAG_DIRTY_BIT = 22;

  localparam int unsigned BUS_QUEUE_DEPTH = 2;

  // **************************************************************************
  // types
  // **************************************************************************

  typedef logic [31:0]                    word_t;
  typedef logic [3:0]                     byte_en_t;
  typedef logic [DATA_RAM_ADDR_WIDTH-1:0] data_addr_t;
  // address bits 10 to 6.
  typedef logic [TAG_RAM_ADDR_WIDTH-1:0]  set_t;
  // address bits 31 to 11.
  typedef logic [TAG_ADDR_WIDTH-1:0]      tag_t;
  typedef logic [1:0]                     way_t;
  typedef logic [BURST_COUNT_WIDTH-1:0]   burst_cnt_t;
  // counts 0 up to and including 16.
  typedef logic [4:0]                     beat_t;

  // commands from the hit/miss logic.
  typedef enum logic [3:0] {
    rw_nop    = 4'd0,
    rw_iorw   = 4'd1,
    rw_refill = 4'd2
  } rw_cmd_e;

endpackage

`default_nettype wire
